//--- logic/vec_pkg.sv
// Vector core package with element, register index and length types and the operation codes
package vec_pkg;

  //////////////////////////////////////////////////
  // Machine sizes
  //////////////////////////////////////////////////

  localparam int unsigned ElemWidth = 16;
  localparam int unsigned NrVRegs   = 8;
  // Longest vector in elements
  localparam int unsigned MaxVl     = 32;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  // One vector element
  typedef logic [ElemWidth-1:0] elem_t;

  // Vector register number
  typedef logic [$clog2(NrVRegs)-1:0] vreg_idx_t;

  // Vector length, 0 up to and including MaxVl
  typedef logic [$clog2(MaxVl+1)-1:0] vl_t;

  // Element position inside one register
  typedef logic [$clog2(MaxVl)-1:0] elem_idx_t;

  // Element-wise operations
  typedef enum logic [2:0] {
    OP_ADD_VV,
    OP_SUB_VV,
    OP_AND_VV,
    OP_XOR_VV,
    OP_ADD_VX
  } vec_op_e;

endpackage

//--- logic/vec_exec_if.sv
`timescale 1ns/10ps
// Execution bus carrying the instruction in flight and the current element group to the lanes
interface vec_exec_if import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4
);

  localparam int unsigned NrGroups   = MaxVl / NrLanes;
  localparam int unsigned GroupWidth = (NrGroups > 1) ? $clog2(NrGroups) : 1;

  // Instruction fields, steady until completion
  vec_op_e   op;
  vreg_idx_t vs1;
  vreg_idx_t vs2;
  vreg_idx_t vd;
  elem_t     scalar;
  vl_t       vl;
  logic      start;

  // Group sequencing
  logic [GroupWidth-1:0] group;
  logic                  group_valid;
  logic                  last;

  modport dispatcher (output op, vs1, vs2, vd, scalar, vl, start, input last);

  modport counter (input start, vl, output group, group_valid, last);

  modport lanes (input op, vs1, vs2, vd, scalar, vl, group, group_valid, last);

endinterface

//--- logic/vec_dispatcher.sv
`timescale 1ns/10ps
// Instruction controller that accepts one instruction at a time and reports its completion
module vec_dispatcher import vec_pkg::*; (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Instruction handshake
  input  logic                  instr_valid_i,
  output logic                  instr_ready_o,
  input  vec_op_e               instr_op_i,
  input  vreg_idx_t             instr_vs1_i,
  input  vreg_idx_t             instr_vs2_i,
  input  vreg_idx_t             instr_vd_i,
  input  elem_t                 instr_scalar_i,
  input  vl_t                   instr_vl_i,
  output logic                  done_o,
  // To counter and lanes
  vec_exec_if.dispatcher        exec
);

  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    DONE
  } state_e;

  state_e    state_q, state_d;
  logic      accept;
  logic      start_q;
  vec_op_e   op_q;
  vreg_idx_t vs1_q;
  vreg_idx_t vs2_q;
  vreg_idx_t vd_q;
  elem_t     scalar_q;
  vl_t       vl_q;

  assign instr_ready_o = (state_q == IDLE);
  assign accept        = instr_valid_i && instr_ready_o;
  assign done_o        = (state_q == DONE);

  //////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // Empty vectors skip execution entirely
        if (accept) begin
          state_d = (instr_vl_i == '0) ? DONE : EXEC;
        end
      end
      EXEC: begin
        if (exec.last) begin
          state_d = DONE;
        end
      end
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      start_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Group 0 runs in the cycle right after acceptance
      start_q <= accept && (instr_vl_i != '0);
    end
  end

  // Instruction latch
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q     <= instr_op_i;
      vs1_q    <= instr_vs1_i;
      vs2_q    <= instr_vs2_i;
      vd_q     <= instr_vd_i;
      scalar_q <= instr_scalar_i;
      vl_q     <= instr_vl_i;
    end
  end

  assign exec.op     = op_q;
  assign exec.vs1    = vs1_q;
  assign exec.vs2    = vs2_q;
  assign exec.vd     = vd_q;
  assign exec.scalar = scalar_q;
  assign exec.vl     = vl_q;
  assign exec.start  = start_q;

endmodule

//--- logic/vec_group_counter.sv
`timescale 1ns/10ps
// Element group counter that steps through one group per cycle and flags the final group
module vec_group_counter import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic         clk_i,
  input  logic         reset_i,
  vec_exec_if.counter  exec
);

  localparam int unsigned NrGroups   = MaxVl / NrLanes;
  localparam int unsigned GroupWidth = (NrGroups > 1) ? $clog2(NrGroups) : 1;
  localparam int unsigned LaneShift  = $clog2(NrLanes);

  logic [GroupWidth-1:0] group_q;
  logic [GroupWidth-1:0] cur_group;
  logic [GroupWidth-1:0] last_group;
  logic                  active_q;
  logic                  grp_valid;
  logic                  grp_last;
  vl_t                   vl_rounded;
  vl_t                   num_groups;

  // Round vl up to whole groups
  assign vl_rounded = exec.vl + vl_t'(NrLanes - 1);
  assign num_groups = vl_rounded >> LaneShift;
  assign last_group = GroupWidth'(num_groups - vl_t'(1));

  // Start forces group 0 in the same cycle
  assign cur_group = exec.start ? '0 : group_q;
  assign grp_valid = exec.start || active_q;
  assign grp_last  = grp_valid && (cur_group == last_group);

  assign exec.group       = cur_group;
  assign exec.group_valid = grp_valid;
  assign exec.last        = grp_last;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q <= 1'b0;
    end else if (grp_valid) begin
      // Stop after the final group
      active_q <= !grp_last;
    end
  end

  always_ff @(posedge clk_i) begin
    if (grp_valid) begin
      group_q <= cur_group + 1'b1;
    end
  end

endmodule

//--- logic/vec_lane.sv
`timescale 1ns/10ps
// Vector lane holding its register file slice, reading operands, computing and writing back
module vec_lane import vec_pkg::*; #(
  parameter  int unsigned NrLanes  = 4,
  parameter  int unsigned LaneId   = 0,
  localparam int unsigned NrRows   = MaxVl / NrLanes,
  localparam int unsigned RowWidth = (NrRows > 1) ? $clog2(NrRows) : 1
) (
  input  logic                clk_i,
  vec_exec_if.lanes           exec,
  // Host write port
  input  logic                wr_en_i,
  input  vreg_idx_t           wr_reg_i,
  input  logic [RowWidth-1:0] wr_row_i,
  input  elem_t               wr_data_i,
  // Host read port
  input  vreg_idx_t           rd_reg_i,
  input  logic [RowWidth-1:0] rd_row_i,
  output elem_t               rd_data_o
);

  // Register slice: every NrLanes-th element of each register
  elem_t vrf_q [NrVRegs][NrRows];

  elem_t               opnd_a;
  elem_t               opnd_b;
  elem_t               result;
  vl_t                 elem_num;
  logic                exec_wr;
  logic                wr_en;
  vreg_idx_t           wr_reg;
  logic [RowWidth-1:0] wr_row;
  elem_t               wr_data;

  //////////////////////////////////////////////////
  // Operand read and ALU
  //////////////////////////////////////////////////

  // Scalar replaces vs1 for the vector-scalar add
  assign opnd_a = (exec.op == OP_ADD_VX) ? exec.scalar : vrf_q[exec.vs1][exec.group];
  assign opnd_b = vrf_q[exec.vs2][exec.group];

  always_comb begin
    case (exec.op)
      OP_ADD_VV, OP_ADD_VX: result = opnd_b + opnd_a;
      // vs2 minus vs1
      OP_SUB_VV:            result = opnd_b - opnd_a;
      OP_AND_VV:            result = opnd_b & opnd_a;
      OP_XOR_VV:            result = opnd_b ^ opnd_a;
      default:              result = opnd_b;
    endcase
  end

  // Global element index of this lane in the current group
  assign elem_num = vl_t'(exec.group) * vl_t'(NrLanes) + vl_t'(LaneId);
  assign exec_wr  = exec.group_valid && (elem_num < exec.vl);

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////

  // Execution owns the port while a group runs
  always_comb begin
    if (exec.group_valid) begin
      wr_en   = exec_wr;
      wr_reg  = exec.vd;
      wr_row  = exec.group;
      wr_data = result;
    end else begin
      wr_en   = wr_en_i;
      wr_reg  = wr_reg_i;
      wr_row  = wr_row_i;
      wr_data = wr_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      vrf_q[wr_reg][wr_row] <= wr_data;
    end
  end

  assign rd_data_o = vrf_q[rd_reg_i][rd_row_i];

endmodule

//--- logic/vec_lane_array.sv
`timescale 1ns/10ps
// Row of identical lanes with host write decode and read-back selection by element index
module vec_lane_array import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic       clk_i,
  vec_exec_if.lanes  exec,
  // Host access by element index
  input  logic       vrf_wr_en_i,
  input  vreg_idx_t  vrf_wr_reg_i,
  input  elem_idx_t  vrf_wr_elem_i,
  input  elem_t      vrf_wr_data_i,
  input  vreg_idx_t  vrf_rd_reg_i,
  input  elem_idx_t  vrf_rd_elem_i,
  output elem_t      vrf_rd_data_o
);

  localparam int unsigned NrRows       = MaxVl / NrLanes;
  localparam int unsigned RowWidth     = (NrRows > 1) ? $clog2(NrRows) : 1;
  localparam int unsigned LaneSelWidth = (NrLanes > 1) ? $clog2(NrLanes) : 1;

  logic [LaneSelWidth-1:0] wr_lane;
  logic [LaneSelWidth-1:0] rd_lane;
  logic [RowWidth-1:0]     wr_row;
  logic [RowWidth-1:0]     rd_row;
  elem_t                   lane_rd_data [NrLanes];

  // Element e sits in lane e mod NrLanes, row e div NrLanes
  assign wr_lane = LaneSelWidth'(vrf_wr_elem_i % NrLanes);
  assign wr_row  = RowWidth'(vrf_wr_elem_i / NrLanes);
  assign rd_lane = LaneSelWidth'(vrf_rd_elem_i % NrLanes);
  assign rd_row  = RowWidth'(vrf_rd_elem_i / NrLanes);

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .NrLanes (NrLanes),
      .LaneId  (l)
    ) u_lane (
      .clk_i     (clk_i),
      .exec      (exec),
      .wr_en_i   (vrf_wr_en_i && (wr_lane == LaneSelWidth'(l))),
      .wr_reg_i  (vrf_wr_reg_i),
      .wr_row_i  (wr_row),
      .wr_data_i (vrf_wr_data_i),
      .rd_reg_i  (vrf_rd_reg_i),
      .rd_row_i  (rd_row),
      .rd_data_o (lane_rd_data[l])
    );
  end : gen_lanes

  assign vrf_rd_data_o = lane_rd_data[rd_lane];

endmodule

//--- logic/vec_core.sv
`timescale 1ns/10ps
// Vector execution core top level joining the controller, group counter and lane array
module vec_core import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic      clk_i,
  input  logic      reset_i,
  // Instruction handshake
  input  logic      instr_valid_i,
  output logic      instr_ready_o,
  input  vec_op_e   instr_op_i,
  input  vreg_idx_t instr_vs1_i,
  input  vreg_idx_t instr_vs2_i,
  input  vreg_idx_t instr_vd_i,
  input  elem_t     instr_scalar_i,
  input  vl_t       instr_vl_i,
  output logic      done_o,
  // Host register file access
  input  logic      vrf_wr_en_i,
  input  vreg_idx_t vrf_wr_reg_i,
  input  elem_idx_t vrf_wr_elem_i,
  input  elem_t     vrf_wr_data_i,
  input  vreg_idx_t vrf_rd_reg_i,
  input  elem_idx_t vrf_rd_elem_i,
  output elem_t     vrf_rd_data_o
);

  // Shared execution bus
  vec_exec_if #(
    .NrLanes (NrLanes)
  ) exec_if ();

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  vec_dispatcher u_dispatcher (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_valid_i  (instr_valid_i),
    .instr_ready_o  (instr_ready_o),
    .instr_op_i     (instr_op_i),
    .instr_vs1_i    (instr_vs1_i),
    .instr_vs2_i    (instr_vs2_i),
    .instr_vd_i     (instr_vd_i),
    .instr_scalar_i (instr_scalar_i),
    .instr_vl_i     (instr_vl_i),
    .done_o         (done_o),
    .exec           (exec_if.dispatcher)
  );

  vec_group_counter #(
    .NrLanes (NrLanes)
  ) u_counter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .exec    (exec_if.counter)
  );

  //////////////////////////////////////////////////
  // Lanes
  //////////////////////////////////////////////////

  vec_lane_array #(
    .NrLanes (NrLanes)
  ) u_lanes (
    .clk_i         (clk_i),
    .exec          (exec_if.lanes),
    .vrf_wr_en_i   (vrf_wr_en_i),
    .vrf_wr_reg_i  (vrf_wr_reg_i),
    .vrf_wr_elem_i (vrf_wr_elem_i),
    .vrf_wr_data_i (vrf_wr_data_i),
    .vrf_rd_reg_i  (vrf_rd_reg_i),
    .vrf_rd_elem_i (vrf_rd_elem_i),
    .vrf_rd_data_o (vrf_rd_data_o)
  );

endmodule

//--- verification/vec_core_model.svh
// Reference model of the vector register file and the element-wise operations
`ifndef VEC_CORE_MODEL_SVH
`define VEC_CORE_MODEL_SVH

// Shadow copy of every register, indexed by element
elem_t model_vrf [NrVRegs][MaxVl];

// Result of one element, vs2 is the left operand
function automatic elem_t model_alu(vec_op_e op, elem_t src1, elem_t src2, elem_t scalar);
  case (op)
    OP_ADD_VV: return src2 + src1;
    OP_SUB_VV: return src2 - src1;
    OP_AND_VV: return src2 & src1;
    OP_XOR_VV: return src2 ^ src1;
    OP_ADD_VX: return src2 + scalar;
    default:   return src2;
  endcase
endfunction

// Elements at or past vl keep their contents
function automatic void model_exec(
  vec_op_e   op,
  vreg_idx_t vs1,
  vreg_idx_t vs2,
  vreg_idx_t vd,
  elem_t     scalar,
  vl_t       vl
);
  for (int e = 0; e < int'(vl); e++) begin
    model_vrf[vd][e] = model_alu(op, model_vrf[vs1][e], model_vrf[vs2][e], scalar);
  end
endfunction

// Cycles from acceptance to done, one per element group plus one
function automatic int model_latency(vl_t vl);
  int groups;
  groups = (int'(vl) + NrLanes - 1) / NrLanes;
  return groups + 1;
endfunction

`endif

//--- verification/vec_core_tb.sv
`timescale 1ns/10ps
// Testbench for the vector core with random instructions checked against a shadow model
module vec_core_tb import vec_pkg::*; ();

  localparam int NrLanes = 4;
  localparam int Timeout = 100;

  logic      clk;
  logic      reset;
  logic      instr_valid;
  logic      instr_ready;
  vec_op_e   instr_op;
  vreg_idx_t instr_vs1;
  vreg_idx_t instr_vs2;
  vreg_idx_t instr_vd;
  elem_t     instr_scalar;
  vl_t       instr_vl;
  logic      done;
  logic      wr_en;
  vreg_idx_t wr_reg;
  elem_idx_t wr_elem;
  elem_t     wr_data;
  vreg_idx_t rd_reg;
  elem_idx_t rd_elem;
  elem_t     rd_data;

  string test_name;
  int    test_errors;
  int    total_errors;
  int    nr_tests;
  int    failed_tests;
  bit    timed_out;

  `include "vec_core_model.svh"

  vec_core #(
    .NrLanes (NrLanes)
  ) u_dut (
    .clk_i          (clk),
    .reset_i        (reset),
    .instr_valid_i  (instr_valid),
    .instr_ready_o  (instr_ready),
    .instr_op_i     (instr_op),
    .instr_vs1_i    (instr_vs1),
    .instr_vs2_i    (instr_vs2),
    .instr_vd_i     (instr_vd),
    .instr_scalar_i (instr_scalar),
    .instr_vl_i     (instr_vl),
    .done_o         (done),
    .vrf_wr_en_i    (wr_en),
    .vrf_wr_reg_i   (wr_reg),
    .vrf_wr_elem_i  (wr_elem),
    .vrf_wr_data_i  (wr_data),
    .vrf_rd_reg_i   (rd_reg),
    .vrf_rd_elem_i  (rd_elem),
    .vrf_rd_data_o  (rd_data)
  );

  always #4 clk = ~clk;

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_elem(elem_t expected, elem_t actual);
    if (expected !== actual) begin
      $display("ERR %s expected %04h actual %04h", test_name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_cycles(int expected, int actual);
    if (expected != actual) begin
      $display("ERR %s expected %0d cycles actual %0d cycles", test_name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_flag(logic expected, logic actual);
    if (expected !== actual) begin
      $display("ERR %s expected %b actual %b", test_name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic start_test(string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    nr_tests++;
    total_errors += test_errors;
    if (test_errors != 0) begin
      failed_tests++;
    end
    $display("%s: %s (%0d errors)", test_name, (test_errors == 0) ? "PASS" : "FAIL",
             test_errors);
  endtask

  //////////////////////////////////////////////////
  // Bus tasks, entered and left 1 ns after an edge
  //////////////////////////////////////////////////

  task automatic host_write(vreg_idx_t r, elem_idx_t e, elem_t data);
    wr_en   = 1'b1;
    wr_reg  = r;
    wr_elem = e;
    wr_data = data;
    @(posedge clk);
    #1;
    wr_en = 1'b0;
    model_vrf[r][e] = data;
  endtask

  // Sweep the whole register file against the shadow copy
  task automatic check_all();
    for (int r = 0; r < NrVRegs; r++) begin
      for (int e = 0; e < MaxVl; e++) begin
        rd_reg  = vreg_idx_t'(r);
        rd_elem = elem_idx_t'(e);
        #2;
        check_elem(model_vrf[r][e], rd_data);
        @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!instr_ready && n < Timeout) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!instr_ready) begin
      $display("%s timed out waiting for ready", test_name);
      test_errors++;
      timed_out = 1'b1;
    end
  endtask

  // Counts cycle 1 as the one right after the acceptance edge
  task automatic wait_done(output int cycles);
    cycles = 1;
    while (!done && cycles <= Timeout) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!done) begin
      $display("%s timed out waiting for done", test_name);
      test_errors++;
      timed_out = 1'b1;
    end
  endtask

  // Leaves valid high after the acceptance edge
  task automatic send(vec_op_e op, vreg_idx_t vs1, vreg_idx_t vs2, vreg_idx_t vd,
                      elem_t scalar, vl_t vl);
    wait_ready();
    if (timed_out) begin
      return;
    end
    instr_valid  = 1'b1;
    instr_op     = op;
    instr_vs1    = vs1;
    instr_vs2    = vs2;
    instr_vd     = vd;
    instr_scalar = scalar;
    instr_vl     = vl;
    @(posedge clk);
    #1;
  endtask

  task automatic run_instr(vec_op_e op, vreg_idx_t vs1, vreg_idx_t vs2, vreg_idx_t vd,
                           elem_t scalar, vl_t vl);
    int cycles;
    send(op, vs1, vs2, vd, scalar, vl);
    if (timed_out) begin
      return;
    end
    instr_valid = 1'b0;
    wait_done(cycles);
    if (timed_out) begin
      return;
    end
    check_cycles(model_latency(vl), cycles);
    model_exec(op, vs1, vs2, vd, scalar, vl);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic run_tests();
    int        cycles;
    vec_op_e   op;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    vreg_idx_t vd;
    elem_t     scalar;
    vl_t       vl;
    vl_t       vl_first;

    start_test("reset_host_rw");
    check_flag(1'b1, instr_ready);
    check_flag(1'b0, done);
    for (int r = 0; r < NrVRegs; r++) begin
      for (int e = 0; e < MaxVl; e++) begin
        host_write(vreg_idx_t'(r), elem_idx_t'(e), elem_t'($urandom));
      end
    end
    check_all();
    end_test();

    // Results and latency of random instructions
    start_test("random_ops");
    repeat (200) begin
      op     = vec_op_e'(3'($urandom_range(0, 4)));
      vs1    = vreg_idx_t'($urandom_range(0, NrVRegs - 1));
      vs2    = vreg_idx_t'($urandom_range(0, NrVRegs - 1));
      vd     = vreg_idx_t'($urandom_range(0, NrVRegs - 1));
      scalar = elem_t'($urandom);
      vl     = vl_t'($urandom_range(1, MaxVl));
      run_instr(op, vs1, vs2, vd, scalar, vl);
      if (timed_out) begin
        return;
      end
      check_all();
    end
    end_test();

    start_test("vl_zero");
    run_instr(OP_XOR_VV, 3'd1, 3'd2, 3'd3, 16'h5a5a, vl_t'(0));
    if (timed_out) begin
      return;
    end
    check_all();
    end_test();

    // Second instruction waits on valid while the first runs, then chains on its vd
    start_test("back_to_back");
    vd       = vreg_idx_t'($urandom_range(0, NrVRegs - 1));
    vl_first = vl_t'($urandom_range(1, MaxVl));
    send(OP_ADD_VV, 3'd0, 3'd1, vd, 16'h0000, vl_first);
    if (timed_out) begin
      return;
    end
    op     = OP_SUB_VV;
    vs2    = vreg_idx_t'($urandom_range(0, NrVRegs - 1));
    vs1    = vd;
    scalar = elem_t'($urandom);
    vl     = vl_t'($urandom_range(1, MaxVl));
    vd     = vreg_idx_t'($urandom_range(0, NrVRegs - 1));
    instr_op     = op;
    instr_vs1    = vs1;
    instr_vs2    = vs2;
    instr_vd     = vd;
    instr_scalar = scalar;
    instr_vl     = vl;
    wait_done(cycles);
    if (timed_out) begin
      return;
    end
    check_cycles(model_latency(vl_first), cycles);
    check_flag(1'b0, instr_ready);
    model_exec(OP_ADD_VV, 3'd0, 3'd1, vs1, 16'h0000, vl_first);
    wait_ready();
    if (timed_out) begin
      return;
    end
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
    wait_done(cycles);
    if (timed_out) begin
      return;
    end
    check_cycles(model_latency(vl), cycles);
    model_exec(op, vs1, vs2, vd, scalar, vl);
    check_all();
    end_test();
  endtask

  initial begin
    void'($urandom(32'hb868));
    clk          = 1'b0;
    reset        = 1'b1;
    instr_valid  = 1'b0;
    instr_op     = OP_ADD_VV;
    instr_vs1    = '0;
    instr_vs2    = '0;
    instr_vd     = '0;
    instr_scalar = '0;
    instr_vl     = '0;
    wr_en        = 1'b0;
    wr_reg       = '0;
    wr_elem      = '0;
    wr_data      = '0;
    rd_reg       = '0;
    rd_elem      = '0;
    total_errors = 0;
    nr_tests     = 0;
    failed_tests = 0;
    timed_out    = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    run_tests();
    $display("summary: %0d tests, %0d failing, %0d errors", nr_tests, failed_tests,
             total_errors + test_errors * int'(timed_out));
    if (timed_out || total_errors != 0) begin
      $display("sim failed");
    end else begin
      $display("sim passed");
    end
    $finish;
  end

endmodule

//--- vec_core.f
+incdir+verification
logic/vec_pkg.sv
logic/vec_exec_if.sv
logic/vec_dispatcher.sv
logic/vec_group_counter.sv
logic/vec_lane.sv
logic/vec_lane_array.sv
logic/vec_core.sv
verification/vec_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the vector core testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vec_core.f --top-module vec_core_tb -o vec_core_sim
./obj_dir/vec_core_sim > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
  exit 1
fi
exit 0
